// File: include/stcDefs.svh
`ifndef STC_DEFS_SVH
`define STC_DEFS_SVH

// sample and control widths
`define SAMPLE_WIDTH 18
`define MU_WIDTH 18             // unsigned, 1.0 is 2^17
`define TAU_WIDTH 6             // signed path delay in samples

// frame layout
`define CODEWORDS_PER_FRAME 16
`define BITS_PER_CODEWORD 4

// readout pacing out of the alignment buffer
`define CLKS_PER_OUTPUT 4

// alignment buffer entries, power of two
`define ALIGN_DEPTH 128

`endif

// File: source/stcPkg.sv
`include "stcDefs.svh"

package stcPkg;

    // one real or imaginary part
    typedef logic signed [`SAMPLE_WIDTH-1:0] sampleT;

    typedef struct packed {
        sampleT re;
        sampleT im;
    } complexSampleT;

    typedef logic [`MU_WIDTH-1:0] muT;              // fractional delay
    typedef logic signed [`TAU_WIDTH-1:0] tauT;     // delay between the two paths

    // everything latched on an estimate strobe
    typedef struct packed {
        complexSampleT h0;
        complexSampleT h1;
        tauT           deltaTau;
        muT            mu;
    } channelEstT;

    typedef logic [`BITS_PER_CODEWORD-1:0] codewordT;

    // frame alignment buffer states
    typedef enum logic [1:0] {
        ALIGN_IDLE,
        ALIGN_ARMED,
        ALIGN_RUN
    } alignStateT;

endpackage

// File: source/detectionFilter.sv
`include "stcDefs.svh"
`timescale 1ns/1ps

module detectionFilter
    import stcPkg::*;
(
    input  logic          clk2x,
    input  logic          reset,
    input  logic          inValid,
    input  complexSampleT inData,
    output logic          outValid,
    output complexSampleT outData
);

    localparam int SUM_WIDTH = `SAMPLE_WIDTH + 2;   // headroom for the gain of 4

    typedef logic signed [SUM_WIDTH-1:0] sumT;

    complexSampleT hist1;       // x[n-1]
    complexSampleT hist2;       // x[n-2]
    sumT           sumRe;
    sumT           sumIm;
    logic          sumValid;

    // 1-2-1 weighting of one part
    function automatic sumT tapSum(sampleT newest, sampleT middle, sampleT oldest);
        return sumT'(newest) + (sumT'(middle) <<< 1) + sumT'(oldest);
    endfunction

    always_ff @(posedge clk2x) begin
        if (reset) begin
            hist1    <= '0;
            hist2    <= '0;
            sumValid <= 1'b0;
            outValid <= 1'b0;
        end else begin
            sumValid <= inValid;
            outValid <= sumValid;
            if (inValid) begin
                hist1 <= inData;
                hist2 <= hist1;
            end
        end
    end

    // adder tree, registered
    always_ff @(posedge clk2x) begin
        if (inValid) begin
            sumRe <= tapSum(inData.re, hist1.re, hist2.re);
            sumIm <= tapSum(inData.im, hist1.im, hist2.im);
        end
    end

    // divide by 4, the sum always fits back into a sample
    always_ff @(posedge clk2x) begin
        if (sumValid) begin
            outData.re <= sampleT'(sumRe >>> 2);
            outData.im <= sampleT'(sumIm >>> 2);
        end
    end

    // both pipeline valids leave reset cleared
    assert property (@(posedge clk2x) $fell(reset) |-> !outValid ##1 !outValid)
        else $error("detectionFilter: outValid high right after reset");

endmodule

// File: source/frameAlignment.sv
`include "stcDefs.svh"
`timescale 1ns/1ps

module frameAlignment
    import stcPkg::*;
(
    input  logic          clk2x,
    input  logic          reset,
    input  logic          inValid,
    input  complexSampleT inData,
    input  logic          frameStart,
    input  logic          estimatesDone,    // estimate latch strobe from the top
    input  logic          lastSampleReset,
    output logic          outValid,
    output complexSampleT outData,
    output logic          startOfTrellis,
    output logic          full
);

    localparam int PTR_WIDTH  = $clog2(`ALIGN_DEPTH);
    localparam int CNT_WIDTH  = PTR_WIDTH + 1;
    localparam int PACE_WIDTH = $clog2(`CLKS_PER_OUTPUT);

    typedef logic [PTR_WIDTH-1:0] ptrT;
    typedef logic [CNT_WIDTH-1:0] cntT;

    alignStateT            state;
    complexSampleT         mem [`ALIGN_DEPTH];
    ptrT                   wrPtr;
    ptrT                   rdPtr;
    ptrT                   wrPtrNext;
    cntT                   count;           // occupancy
    cntT                   armedCount;      // samples written since frameStart
    cntT                   armedNext;
    logic [PACE_WIDTH-1:0] paceCnt;
    logic                  doWrite;
    logic                  doRead;
    logic                  startRun;

    assign doWrite   = inValid && (state != ALIGN_RUN);
    assign startRun  = (state == ALIGN_ARMED) && estimatesDone;
    assign wrPtrNext = wrPtr + ptrT'(doWrite);
    assign full      = (count == cntT'(`ALIGN_DEPTH));

    // no read on the frame end cycle, so outValid never lands in IDLE
    assign doRead = (state == ALIGN_RUN) && !lastSampleReset && (count != '0)
                    && (paceCnt == PACE_WIDTH'(`CLKS_PER_OUTPUT - 1));

    assign armedNext = (doWrite && (armedCount != cntT'(`ALIGN_DEPTH))) ?
                       armedCount + 1'b1 : armedCount;

    always_ff @(posedge clk2x) begin
        if (reset) begin
            state          <= ALIGN_IDLE;
            wrPtr          <= '0;
            rdPtr          <= '0;
            count          <= '0;
            armedCount     <= '0;
            paceCnt        <= '0;
            startOfTrellis <= 1'b0;
            outValid       <= 1'b0;
        end else begin
            startOfTrellis <= startRun;
            outValid       <= doRead;
            wrPtr          <= wrPtrNext;

            case (state)
                ALIGN_IDLE:  if (frameStart) state <= ALIGN_ARMED;
                ALIGN_ARMED: if (estimatesDone) state <= ALIGN_RUN;
                ALIGN_RUN:   if (lastSampleReset) state <= ALIGN_IDLE;
                default:     state <= ALIGN_IDLE;
            endcase

            // a write on the frameStart cycle already belongs to the frame
            if (state == ALIGN_IDLE) begin
                armedCount <= cntT'(frameStart && doWrite);
            end else begin
                armedCount <= armedNext;
            end

            if (startRun) begin
                // drop everything older than the frame start
                count <= armedNext;
                rdPtr <= wrPtrNext - ptrT'(armedNext);
            end else if (doWrite) begin
                if (full) begin
                    rdPtr <= rdPtr + 1'b1;  // oldest sample overwritten
                end else begin
                    count <= count + 1'b1;
                end
            end else if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
                count <= count - 1'b1;
            end

            if (state != ALIGN_RUN) begin
                paceCnt <= '0;
            end else if (paceCnt == PACE_WIDTH'(`CLKS_PER_OUTPUT - 1)) begin
                paceCnt <= '0;
            end else begin
                paceCnt <= paceCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk2x) begin
        if (doWrite) mem[wrPtr] <= inData;
        if (doRead) outData <= mem[rdPtr];
    end

    assert property (@(posedge clk2x) disable iff (reset) count <= cntT'(`ALIGN_DEPTH))
        else $error("frameAlignment: occupancy %0d over depth", count);

    assert property (@(posedge clk2x) disable iff (reset) outValid |-> state == ALIGN_RUN)
        else $error("frameAlignment: outValid outside of RUN");

endmodule

// File: source/interpolator.sv
`include "stcDefs.svh"
`timescale 1ns/1ps

module interpolator
    import stcPkg::*;
(
    input  logic          clk2x,
    input  logic          reset,
    input  logic          clear,
    input  logic          inValid,
    input  complexSampleT inData,
    input  muT            mu,
    output logic          outValid,
    output complexSampleT outData
);

    localparam int DIFF_WIDTH = `SAMPLE_WIDTH + 1;
    localparam int PROD_WIDTH = DIFF_WIDTH + `MU_WIDTH + 1;
    localparam int MU_FRAC    = `MU_WIDTH - 1;

    localparam logic signed [PROD_WIDTH-1:0] SAT_MAX = 2 ** (`SAMPLE_WIDTH - 1) - 1;
    localparam logic signed [PROD_WIDTH-1:0] SAT_MIN = -(2 ** (`SAMPLE_WIDTH - 1));

    complexSampleT prevSample;

    // prev + mu * (cur - prev), rounded and clipped
    function automatic sampleT interpPart(sampleT cur, sampleT prev, muT frac);
        logic signed [DIFF_WIDTH-1:0] diff;
        logic signed [PROD_WIDTH-1:0] prod;
        logic signed [PROD_WIDTH-1:0] acc;
        diff = DIFF_WIDTH'(cur) - DIFF_WIDTH'(prev);
        prod = diff * $signed({1'b0, frac});
        acc  = (prod + (PROD_WIDTH'(1) <<< (MU_FRAC - 1))) >>> MU_FRAC;
        acc  = acc + PROD_WIDTH'(prev);
        if (acc > SAT_MAX) begin
            acc = SAT_MAX;
        end else if (acc < SAT_MIN) begin
            acc = SAT_MIN;
        end
        return sampleT'(acc);
    endfunction

    always_ff @(posedge clk2x) begin
        if (reset) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // history restarts with each trellis
    always_ff @(posedge clk2x) begin
        if (reset || clear) begin
            prevSample <= '0;
        end else if (inValid) begin
            prevSample <= inData;
        end
    end

    always_ff @(posedge clk2x) begin
        if (inValid) begin
            outData.re <= interpPart(inData.re, prevSample.re, mu);
            outData.im <= interpPart(inData.im, prevSample.im, mu);
        end
    end

endmodule

// File: source/stcDetector.sv
`include "stcDefs.svh"
`timescale 1ns/1ps

module stcDetector
    import stcPkg::*;
(
    input  logic          clk2x,
    input  logic          reset,
    input  logic          clear,
    input  logic          inValid,
    input  complexSampleT inData,
    input  channelEstT    est,
    output logic          cwValid,
    output codewordT      cwBits
);

    localparam int DELAY_DEPTH  = 32;
    localparam int DELAY_SEL    = $clog2(DELAY_DEPTH);
    localparam int METRIC_WIDTH = 2 * `SAMPLE_WIDTH + 2;
    localparam int CNT_WIDTH    = $clog2(`BITS_PER_CODEWORD);
    localparam int LAST_BIT     = `BITS_PER_CODEWORD - 1;

    typedef logic signed [METRIC_WIDTH-1:0] metricT;

    complexSampleT                 delayLine [DELAY_DEPTH];  // [0] is x[n-1]
    complexSampleT                 delayed;
    logic [`TAU_WIDTH:0]           delayAbs;
    metricT                        metric;
    logic                          decision;
    logic [`BITS_PER_CODEWORD-2:0] shiftReg;
    logic [CNT_WIDTH-1:0]          bitCnt;

    // real part of conj(h) * x
    function automatic metricT realConjProd(complexSampleT h, complexSampleT x);
        metricT reProd;
        metricT imProd;
        reProd = h.re * x.re;
        imProd = h.im * x.im;
        return reProd + imProd;
    endfunction

    // one extra bit so that |-32| fits
    assign delayAbs = est.deltaTau[`TAU_WIDTH-1] ?
                      -{est.deltaTau[`TAU_WIDTH-1], est.deltaTau} :
                      {1'b0, est.deltaTau};

    always_comb begin
        if (delayAbs == '0) begin
            delayed = inData;
        end else begin
            delayed = delayLine[DELAY_SEL'(delayAbs - 1'b1)];
        end
    end

    assign metric   = realConjProd(est.h0, inData) + realConjProd(est.h1, delayed);
    assign decision = metric[METRIC_WIDTH-1];  // negative metric means 1

    always_ff @(posedge clk2x) begin
        if (inValid) begin
            delayLine[0] <= inData;
            for (int i = 1; i < DELAY_DEPTH; i++) begin
                delayLine[i] <= delayLine[i-1];
            end
        end
    end

    always_ff @(posedge clk2x) begin
        if (reset || clear) begin
            bitCnt  <= '0;
            cwValid <= 1'b0;
        end else begin
            cwValid <= inValid && (bitCnt == CNT_WIDTH'(LAST_BIT));
            if (inValid) begin
                bitCnt <= (bitCnt == CNT_WIDTH'(LAST_BIT)) ? '0 : bitCnt + 1'b1;
            end
        end
    end

    // first decision of a codeword ends up in the MSB
    always_ff @(posedge clk2x) begin
        if (inValid) begin
            shiftReg <= {shiftReg[`BITS_PER_CODEWORD-3:0], decision};
            if (bitCnt == CNT_WIDTH'(LAST_BIT)) cwBits <= {shiftReg, decision};
        end
    end

endmodule

// File: source/trellisProcess.sv
`include "stcDefs.svh"
`timescale 1ns/1ps

module trellisProcess
    import stcPkg::*;
(
    input  logic          clk2x,
    input  logic          reset,
    input  logic          sampleValid,
    input  complexSampleT din,
    input  logic          frameStart,
    input  logic          estimatesDone,
    input  complexSampleT h0EstIn,
    input  complexSampleT h1EstIn,
    input  tauT           deltaTauEstIn,
    input  muT            muIn,
    output complexSampleT sample0,
    output logic          interpOutEn,
    output logic          outputEn,
    output codewordT      outputBits,
    output logic          lastSampleReset,
    output logic          full
);

    localparam int CW_CNT_WIDTH = $clog2(`CODEWORDS_PER_FRAME + 3);

    typedef logic [CW_CNT_WIDTH-1:0] cwCountT;

    logic          filtValid;
    complexSampleT filtData;
    logic          alignValid;
    complexSampleT alignData;
    logic          startOfTrellis;
    logic          interpValid;
    complexSampleT interpData;
    logic          cwValid;
    codewordT      cwBits;
    logic          estimatesDoneDly;
    channelEstT    est;
    cwCountT       cwCount;
    cwCountT       frameEndCount;
    logic [1:0]    spareCount;     // leading codewords to drop
    logic          inWindow;

    detectionFilter detectionFilter_i (
        .clk2x    (clk2x),
        .reset    (reset),
        .inValid  (sampleValid),
        .inData   (din),
        .outValid (filtValid),
        .outData  (filtData)
    );

    frameAlignment frameAlignment_i (
        .clk2x           (clk2x),
        .reset           (reset),
        .inValid         (filtValid),
        .inData          (filtData),
        .frameStart      (frameStart),
        .estimatesDone   (estimatesDoneDly),
        .lastSampleReset (lastSampleReset),
        .outValid        (alignValid),
        .outData         (alignData),
        .startOfTrellis  (startOfTrellis),
        .full            (full)
    );

    interpolator interpolator_i (
        .clk2x    (clk2x),
        .reset    (reset),
        .clear    (startOfTrellis),
        .inValid  (alignValid),
        .inData   (alignData),
        .mu       (est.mu),
        .outValid (interpValid),
        .outData  (interpData)
    );

    stcDetector stcDetector_i (
        .clk2x   (clk2x),
        .reset   (reset),
        .clear   (startOfTrellis),
        .inValid (interpValid),
        .inData  (interpData),
        .est     (est),
        .cwValid (cwValid),
        .cwBits  (cwBits)
    );

    assign sample0     = interpData;
    assign interpOutEn = interpValid;

    assign frameEndCount   = cwCountT'(`CODEWORDS_PER_FRAME) + cwCountT'(spareCount);
    assign lastSampleReset = (cwCount == frameEndCount);
    assign inWindow        = (cwCount >= cwCountT'(spareCount)) && (cwCount < frameEndCount);

    // estimates are taken one cycle after the strobe
    always_ff @(posedge clk2x) begin
        if (reset) begin
            estimatesDoneDly <= 1'b0;
        end else begin
            estimatesDoneDly <= estimatesDone;
        end
    end

    always_ff @(posedge clk2x) begin
        if (estimatesDoneDly) begin
            est <= '{h0: h0EstIn, h1: h1EstIn, deltaTau: deltaTauEstIn, mu: muIn};
        end
    end

    always_ff @(posedge clk2x) begin
        if (reset) begin
            spareCount <= 2'd1;   // only one spare on the first frame
            cwCount    <= '0;
            outputEn   <= 1'b0;
            outputBits <= '0;
        end else begin
            if (lastSampleReset) spareCount <= 2'd2;

            if (startOfTrellis || lastSampleReset) begin
                cwCount <= '0;
            end else if (cwValid) begin
                cwCount <= cwCount + 1'b1;
            end

            outputEn <= cwValid && inWindow;
            if (cwValid && inWindow) outputBits <= cwBits;
        end
    end

    // the counter clears on the frame end, so the pulse is a single cycle
    assert property (@(posedge clk2x) disable iff (reset) lastSampleReset |=> !lastSampleReset)
        else $error("trellisProcess: lastSampleReset high for two cycles");

endmodule

// File: tb/trellisProcessTb.sv
`include "stcDefs.svh"
`timescale 1ns/1ps

module trellisProcessTb
    import stcPkg::*;
();

    localparam int FRAME_SAMPLES = 80;      // enough for 18 codewords of 4 samples
    localparam int LEAD_SAMPLES  = 4;       // settles the filter history
    localparam int FRAME_TIMEOUT = 4000;
    localparam int ONE_EST       = 2 ** (`SAMPLE_WIDTH - 2);
    localparam int MU_HALF       = 2 ** (`MU_WIDTH - 2);

    logic          clk2x;
    logic          reset;
    logic          sampleValid;
    complexSampleT din;
    logic          frameStart;
    logic          estimatesDone;
    complexSampleT h0EstIn;
    complexSampleT h1EstIn;
    tauT           deltaTauEstIn;
    muT            muIn;
    complexSampleT sample0;
    logic          interpOutEn;
    logic          outputEn;
    codewordT      outputBits;
    logic          lastSampleReset;
    logic          full;

    logic [31:0]   lfsrState = 32'hb0f8172f;
    logic          idleCheck = 1'b1;
    logic          checkBits = 1'b0;
    logic          checkSample = 1'b0;
    logic          countClear = 1'b0;
    logic          timedOut = 1'b0;
    codewordT      expBits = '0;
    complexSampleT expSample = '0;
    int            outEnCount = 0;
    int            interpCount = 0;
    int            frameEndCount = 0;
    int            assertFails = 0;
    int            checkFails = 0;
    int            errorsAtStart = 0;
    int            passCount = 0;
    int            failCount = 0;
    int            spareExp = 1;         // one spare codeword on the first frame only
    complexSampleT frameValue;

    trellisProcess trellisProcess_i (.*);

    initial begin
        clk2x = 1'b0;
        forever #10 clk2x = ~clk2x;
    end

    // per frame event counters
    always @(posedge clk2x) begin
        if (countClear) begin
            outEnCount    <= 0;
            interpCount   <= 0;
            frameEndCount <= 0;
        end else begin
            if (outputEn) outEnCount <= outEnCount + 1;
            if (interpOutEn) interpCount <= interpCount + 1;
            if (lastSampleReset) frameEndCount <= frameEndCount + 1;
        end
    end

    assert property (@(posedge clk2x) disable iff (reset)
            idleCheck |-> !(outputEn || interpOutEn || lastSampleReset || full))
        else begin
            $display("mismatch {outputEn,interpOutEn,lastSampleReset,full} expected %h actual %h",
                     4'h0, $sampled({outputEn, interpOutEn, lastSampleReset, full}));
            assertFails++;
        end

    assert property (@(posedge clk2x) disable iff (reset) idleCheck |-> outputBits == '0)
        else begin
            $display("mismatch outputBits expected %h actual %h", 4'h0, $sampled(outputBits));
            assertFails++;
        end

    assert property (@(posedge clk2x) disable iff (reset)
            checkBits && outputEn |-> outputBits == expBits)
        else begin
            $display("mismatch outputBits expected %h actual %h", expBits, $sampled(outputBits));
            assertFails++;
        end

    // first output of a trellis still mixes in the cleared history
    assert property (@(posedge clk2x) disable iff (reset)
            checkSample && interpOutEn && interpCount != 0 |-> sample0 == expSample)
        else begin
            $display("mismatch sample0 expected %h actual %h", expSample, $sampled(sample0));
            assertFails++;
        end

    initial begin
        wait (timedOut);
        $display("TEST FAILED");
        $finish;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    task automatic randomSample(input logic negative, output complexSampleT value);
        logic [31:0] bits;
        takeBits(12, bits);
        value.re = sampleT'(1000 + bits[11:0]);
        if (negative) value.re = -value.re;
        takeBits(8, bits);
        value.im = sampleT'(bits[7:0]) - sampleT'(128);
    endtask

    task automatic nextDrive();
        @(posedge clk2x);
        #2;
    endtask

    // one strobe every second cycle
    task automatic sendSamples(input int n, input complexSampleT value);
        repeat (n) begin
            nextDrive();
            sampleValid = 1'b1;
            din         = value;
            nextDrive();
            sampleValid = 1'b0;
        end
    endtask

    task automatic setEstimates(input int h0Re, input int mu);
        h0EstIn       = '{re: sampleT'(h0Re), im: '0};
        h1EstIn       = '0;
        deltaTauEstIn = '0;
        muIn          = muT'(mu);
    endtask

    task automatic waitFrameEnd();
        int cycles;
        cycles = 0;
        while (!lastSampleReset && cycles < FRAME_TIMEOUT) begin
            @(posedge clk2x);
            #1;
            cycles++;
        end
        if (!lastSampleReset) begin
            $display("timeout, lastSampleReset never came");
            timedOut = 1'b1;
            @(posedge clk2x);
        end
    endtask

    task automatic checkCount(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("mismatch %s expected %h actual %h", name, expected, actual);
            checkFails++;
        end
    endtask

    task automatic finishTest(input int num, input string name);
        logic ok;
        ok = (assertFails + checkFails) == errorsAtStart;
        if (ok) passCount++;
        else failCount++;
        $display("test %0d %s %s", num, name, ok ? "passed" : "failed");
        errorsAtStart = assertFails + checkFails;
    endtask

    // arm, fill, start and drain one frame
    task automatic runFrame(input complexSampleT value, input codewordT bits,
                            input logic flipEst);
        sendSamples(LEAD_SAMPLES, value);
        repeat (4) @(posedge clk2x);
        nextDrive();
        frameStart = 1'b1;
        nextDrive();
        frameStart = 1'b0;
        sendSamples(FRAME_SAMPLES, value);
        repeat (4) @(posedge clk2x);
        nextDrive();
        estimatesDone = 1'b1;
        countClear    = 1'b1;
        expBits       = bits;
        expSample     = value;
        checkBits     = 1'b1;
        nextDrive();
        estimatesDone = 1'b0;
        countClear    = 1'b0;
        if (flipEst) begin
            repeat (4) nextDrive();
            h0EstIn = '{re: -h0EstIn.re, im: h0EstIn.im};  // no strobe, must be ignored
        end
        waitFrameEnd();
        repeat (20) @(posedge clk2x);
        checkBits   = 1'b0;
        checkSample = 1'b0;
        checkCount("outEnCount", `CODEWORDS_PER_FRAME, outEnCount);
        checkCount("interpCount", `BITS_PER_CODEWORD * (`CODEWORDS_PER_FRAME + spareExp),
                   interpCount);
        checkCount("frameEndCount", 1, frameEndCount);
        spareExp = 2;
    endtask

    initial begin
        reset         = 1'b1;
        sampleValid   = 1'b0;
        din           = '0;
        frameStart    = 1'b0;
        estimatesDone = 1'b0;
        setEstimates(ONE_EST, 0);
        repeat (10) @(posedge clk2x);
        #2;
        reset = 1'b0;

        randomSample(1'b0, frameValue);
        sendSamples(40, frameValue);
        repeat (10) @(posedge clk2x);
        finishTest(1, "idle outputs after reset");

        nextDrive();
        idleCheck = 1'b0;
        randomSample(1'b0, frameValue);
        sendSamples(`ALIGN_DEPTH + 12, frameValue);
        repeat (4) @(posedge clk2x);
        #1;
        if (full !== 1'b1) begin
            $display("mismatch full expected %h actual %h", 1'b1, full);
            checkFails++;
        end
        finishTest(2, "buffer full flag");

        randomSample(1'b0, frameValue);
        runFrame(frameValue, 4'b0000, 1'b0);
        if (full !== 1'b0) begin
            $display("mismatch full expected %h actual %h", 1'b0, full);
            checkFails++;
        end
        finishTest(3, "positive frame, first frame count, full drop");

        randomSample(1'b1, frameValue);
        runFrame(frameValue, 4'b1111, 1'b1);
        finishTest(4, "negative frame with unstrobed estimate change");

        nextDrive();
        setEstimates(-ONE_EST, 0);
        randomSample(1'b0, frameValue);
        runFrame(frameValue, 4'b1111, 1'b0);
        finishTest(5, "positive frame with inverted h0");

        nextDrive();
        setEstimates(ONE_EST, MU_HALF);
        checkSample = 1'b1;
        randomSample(1'b0, frameValue);
        runFrame(frameValue, 4'b0000, 1'b0);
        finishTest(6, "half sample interpolation");

        $display("tests passed %0d, tests failing %0d", passCount, failCount);
        if (failCount == 0 && (assertFails + checkFails) == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: trellisProcess.f
+incdir+include
source/stcPkg.sv
source/detectionFilter.sv
source/frameAlignment.sv
source/interpolator.sv
source/stcDetector.sv
source/trellisProcess.sv
tb/trellisProcessTb.sv

// File: build.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f trellisProcess.f \
    --top-module trellisProcessTb -o trellisProcessSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/trellisProcessSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
